// File: include/bf_consts.svh
`ifndef BF_CONSTS_SVH
`define BF_CONSTS_SVH

// beams per fifo word, one complex sample each
`define BF_NUM_BEAMS 4

// antenna elements per beam
`define BF_NUM_ELEMENTS 8

// signed sample or weight component
`define BF_SAMPLE_W 16

// signed product component
// wide enough for the full 16x16 product, sums wrap
`define BF_PRODUCT_W 32

`endif

// File: hdl/bf_sample_pkg.sv
`include "bf_consts.svh"

package bf_sample_pkg;

    // one real or imaginary part of a sample or weight
    typedef logic signed [`BF_SAMPLE_W-1:0] comp_t;

    // complex value, imag in upper half, real in lower half
    typedef logic [2*`BF_SAMPLE_W-1:0] cplx_t;

    // one real or imaginary part of a product
    typedef logic signed [`BF_PRODUCT_W-1:0] prod_comp_t;

    // complex product, same imag-upper layout
    typedef logic [2*`BF_PRODUCT_W-1:0] cplx_prod_t;

    // fifo word, indexed by beam
    typedef cplx_t [`BF_NUM_BEAMS-1:0] sample_bus_t;

    // one output beat, indexed [beam][element]
    typedef prod_comp_t [`BF_NUM_BEAMS-1:0][`BF_NUM_ELEMENTS-1:0] component_bus_t;

endpackage

// File: hdl/tx_ctrl_pkg.sv
package tx_ctrl_pkg;

    // sequencer states, one pass per fifo word
    typedef enum logic [2:0] {
        IDLE,
        READ,
        LOAD,
        BEAT_RE,
        BEAT_IM
    } tx_state_t;

endpackage

// File: hdl/weight_rom.sv
`timescale 1ns/1ps

module weight_rom #(
    parameter int BEAM    = 0,
    parameter int ELEMENT = 0
) (
    output bf_sample_pkg::cplx_t weight
);

    // table key, beam in upper bits, element in lower bits
    localparam logic [4:0] rom_sel = {2'(BEAM), 3'(ELEMENT)};

    // entries are {imag, real}
    // element 0 is unity gain on every beam
    always_comb begin
        case (rom_sel)
            // beam 0
            5'd0:  weight = {16'h0000, 16'h7fff};
            5'd1:  weight = {16'hdd64, 16'h7b3b};
            5'd2:  weight = {16'hbd5b, 16'h6d48};
            5'd3:  weight = {16'ha24a, 16'h5731};
            5'd4:  weight = {16'h8e34, 16'h3a9b};
            5'd5:  weight = {16'h8299, 16'h19a6};
            5'd6:  weight = {16'h8055, 16'hf6c9};
            5'd7:  weight = {16'h8794, 16'hd49b};

            // beam 1
            5'd8:  weight = {16'h0000, 16'h7fff};
            5'd9:  weight = {16'h83c4, 16'h1ed0};
            5'd10: weight = {16'hc430, 16'h8ed5};
            5'd11: weight = {16'h5f71, 16'haab5};
            5'd12: weight = {16'h69c2, 16'h48ab};
            5'd13: weight = {16'hd379, 16'h7802};
            5'd14: weight = {16'h80ce, 16'hf1ac};
            5'd15: weight = {16'hef4a, 16'h8118};

            // beam 2
            5'd16: weight = {16'h0000, 16'h7fff};
            5'd17: weight = {16'h9a27, 16'hb278};
            5'd18: weight = {16'h7b61, 16'hddeb};
            5'd19: weight = {16'hd063, 16'h76d1};
            5'd20: weight = {16'hbe4d, 16'h9226};
            5'd21: weight = {16'h7f34, 16'h0e42};
            5'd22: weight = {16'ha79b, 16'h5c94};
            5'd23: weight = {16'hebe0, 16'h8198};

            // beam 3
            5'd24: weight = {16'h0000, 16'h7fff};
            5'd25: weight = {16'hdade, 16'h8581};
            5'd26: weight = {16'h4713, 16'h6a74};
            5'd27: weight = {16'h9d19, 16'haebe};
            5'd28: weight = {16'h7639, 16'h3112};
            5'd29: weight = {16'h80a1, 16'hf357};
            5'd30: weight = {16'h7d91, 16'he72a};
            5'd31: weight = {16'h8f0a, 16'h3c32};

            default: weight = '0;
        endcase
    end

endmodule

// File: hdl/cplx_mult.sv
`timescale 1ns/1ps

module cplx_mult #(
    parameter int BEAM    = 0,
    parameter int ELEMENT = 0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      load,
    input  bf_sample_pkg::cplx_t      sample,
    output bf_sample_pkg::cplx_prod_t product
);

    localparam int cw = $bits(bf_sample_pkg::comp_t);

    bf_sample_pkg::cplx_t      weight;
    bf_sample_pkg::comp_t      a;
    bf_sample_pkg::comp_t      b;
    bf_sample_pkg::comp_t      c;
    bf_sample_pkg::comp_t      d;
    bf_sample_pkg::prod_comp_t next_re;
    bf_sample_pkg::prod_comp_t next_im;
    bf_sample_pkg::prod_comp_t prod_re;
    bf_sample_pkg::prod_comp_t prod_im;

    weight_rom #(.BEAM(BEAM), .ELEMENT(ELEMENT)) i_weight_rom (.weight(weight));

    // sample is a + jb, weight is c + jd
    assign a = sample[cw-1:0];
    assign b = sample[2*cw-1:cw];
    assign c = weight[cw-1:0];
    assign d = weight[2*cw-1:cw];

    // sign-extend first, 32-bit math wraps to the truncated result
    assign next_re = bf_sample_pkg::prod_comp_t'(a) * bf_sample_pkg::prod_comp_t'(c)
                   - bf_sample_pkg::prod_comp_t'(b) * bf_sample_pkg::prod_comp_t'(d);
    assign next_im = bf_sample_pkg::prod_comp_t'(a) * bf_sample_pkg::prod_comp_t'(d)
                   + bf_sample_pkg::prod_comp_t'(b) * bf_sample_pkg::prod_comp_t'(c);

    // product holds between loads
    always_ff @(posedge clk) begin
        if (reset) begin
            prod_re <= '0;
            prod_im <= '0;
        end else if (load) begin
            prod_re <= next_re;
            prod_im <= next_im;
        end
    end

    assign product = {prod_im, prod_re};

endmodule

// File: hdl/beam_product_array.sv
`timescale 1ns/1ps
`include "bf_consts.svh"

module beam_product_array (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          load,
    input  logic                          is_imag,
    input  bf_sample_pkg::sample_bus_t    samples,
    output bf_sample_pkg::component_bus_t out_data
);

    localparam int pw = $bits(bf_sample_pkg::prod_comp_t);

    // registered products, [beam][element]
    bf_sample_pkg::cplx_prod_t products [`BF_NUM_BEAMS][`BF_NUM_ELEMENTS];

    // every element of a beam sees the same sample
    for (genvar bm = 0; bm < `BF_NUM_BEAMS; bm++) begin : g_beam
        for (genvar el = 0; el < `BF_NUM_ELEMENTS; el++) begin : g_elem
            cplx_mult #(
                .BEAM(bm),
                .ELEMENT(el)
            ) i_cplx_mult (
                .clk(clk),
                .reset(reset),
                .load(load),
                .sample(samples[bm]),
                .product(products[bm][el])
            );
        end
    end

    // real halves on the first beat, imag halves on the second
    always_comb begin
        for (int bm = 0; bm < `BF_NUM_BEAMS; bm++) begin
            for (int el = 0; el < `BF_NUM_ELEMENTS; el++) begin
                if (is_imag) begin
                    out_data[bm][el] = products[bm][el][2*pw-1:pw];
                end else begin
                    out_data[bm][el] = products[bm][el][pw-1:0];
                end
            end
        end
    end

endmodule

// File: hdl/tx_sequencer.sv
`timescale 1ns/1ps

module tx_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic fifo_empty,
    input  logic rx_ready,
    output logic fifo_rd_en,
    output logic load,
    output logic out_valid,
    output logic is_imag
);

    tx_ctrl_pkg::tx_state_t state;
    tx_ctrl_pkg::tx_state_t state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= tx_ctrl_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // rx_ready only matters in idle, a started word always finishes
    always_comb begin
        state_next = state;
        case (state)
            tx_ctrl_pkg::IDLE: begin
                if (rx_ready && !fifo_empty) begin
                    state_next = tx_ctrl_pkg::READ;
                end
            end
            // fifo word lands on sample_in during load
            tx_ctrl_pkg::READ:    state_next = tx_ctrl_pkg::LOAD;
            tx_ctrl_pkg::LOAD:    state_next = tx_ctrl_pkg::BEAT_RE;
            tx_ctrl_pkg::BEAT_RE: state_next = tx_ctrl_pkg::BEAT_IM;
            tx_ctrl_pkg::BEAT_IM: state_next = tx_ctrl_pkg::IDLE;
            default:              state_next = tx_ctrl_pkg::IDLE;
        endcase
    end

    // outputs straight from the state register
    assign fifo_rd_en = (state == tx_ctrl_pkg::READ);
    assign load       = (state == tx_ctrl_pkg::LOAD);
    assign out_valid  = (state == tx_ctrl_pkg::BEAT_RE) || (state == tx_ctrl_pkg::BEAT_IM);
    assign is_imag    = (state == tx_ctrl_pkg::BEAT_IM);

    // one-cycle read strobe
    a_rd_single : assert property (@(posedge clk) disable iff (reset)
        fifo_rd_en |=> !fifo_rd_en);

    // imag beat only right after a real beat
    a_re_before_im : assert property (@(posedge clk) disable iff (reset)
        (out_valid && is_imag) |-> $past(out_valid && !is_imag));

    // capture lines up with the fifo read latency
    a_load_after_rd : assert property (@(posedge clk) disable iff (reset)
        load == $past(fifo_rd_en));

endmodule

// File: hdl/beam_weight_tx.sv
`timescale 1ns/1ps
`include "bf_consts.svh"

module beam_weight_tx (
    input  logic                          clk,
    input  logic                          reset,
    input  bf_sample_pkg::sample_bus_t    sample_in,
    input  logic                          fifo_empty,
    input  logic                          rx_ready,
    output logic                          fifo_rd_en,
    output logic                          out_valid,
    output logic                          out_is_imag,
    output bf_sample_pkg::component_bus_t out_data
);

    // multiplier capture strobe
    logic load;

    tx_sequencer i_tx_sequencer (
        .clk(clk),
        .reset(reset),
        .fifo_empty(fifo_empty),
        .rx_ready(rx_ready),
        .fifo_rd_en(fifo_rd_en),
        .load(load),
        .out_valid(out_valid),
        .is_imag(out_is_imag)
    );

    beam_product_array i_beam_product_array (
        .clk(clk),
        .reset(reset),
        .load(load),
        .is_imag(out_is_imag),
        .samples(sample_in),
        .out_data(out_data)
    );

endmodule

// File: tests/tb_beam_weight_tx.sv
`timescale 1ns/1ps
`include "bf_consts.svh"

module tb_beam_weight_tx;

    // weight table as {imag, real} words indexed by beam * 8 + element
    localparam logic [31:0] weight_tab [32] = '{
        32'h0000_7fff, 32'hdd64_7b3b, 32'hbd5b_6d48, 32'ha24a_5731,
        32'h8e34_3a9b, 32'h8299_19a6, 32'h8055_f6c9, 32'h8794_d49b,
        32'h0000_7fff, 32'h83c4_1ed0, 32'hc430_8ed5, 32'h5f71_aab5,
        32'h69c2_48ab, 32'hd379_7802, 32'h80ce_f1ac, 32'hef4a_8118,
        32'h0000_7fff, 32'h9a27_b278, 32'h7b61_ddeb, 32'hd063_76d1,
        32'hbe4d_9226, 32'h7f34_0e42, 32'ha79b_5c94, 32'hebe0_8198,
        32'h0000_7fff, 32'hdade_8581, 32'h4713_6a74, 32'h9d19_aebe,
        32'h7639_3112, 32'h80a1_f357, 32'h7d91_e72a, 32'h8f0a_3c32
    };

    logic                          clk = 1'b0;
    logic                          reset = 1'b1;
    bf_sample_pkg::sample_bus_t    sample_in = '0;
    logic                          fifo_empty = 1'b1;
    logic                          rx_ready = 1'b0;
    logic                          fifo_rd_en;
    logic                          out_valid;
    logic                          out_is_imag;
    bf_sample_pkg::component_bus_t out_data;

    // fifo contents and the words read but not yet checked
    bf_sample_pkg::sample_bus_t    fifo_q [$];
    bf_sample_pkg::sample_bus_t    exp_q [$];
    bf_sample_pkg::sample_bus_t    cur_word = '0;
    bf_sample_pkg::component_bus_t last_re;
    bf_sample_pkg::component_bus_t last_im;
    // cycle numbers of read strobes and of out_valid rising
    int   rd_cycles [$];
    int   rise_cycles [$];
    int   cycle = 0;
    int   rd_count = 0;
    int   beat_count = 0;
    int   errors = 0;
    int   checks = 0;
    logic want_imag = 1'b0;
    logic valid_d = 1'b0;

    beam_weight_tx i_beam_weight_tx (
        .clk(clk),
        .reset(reset),
        .sample_in(sample_in),
        .fifo_empty(fifo_empty),
        .rx_ready(rx_ready),
        .fifo_rd_en(fifo_rd_en),
        .out_valid(out_valid),
        .out_is_imag(out_is_imag),
        .out_data(out_data)
    );

    // 100 ns period
    always #50 clk = ~clk;

    function automatic longint to_long(input bf_sample_pkg::comp_t x);
        return longint'(x);
    endfunction

    // expected beat from exact 64-bit math truncated to the product width
    function automatic bf_sample_pkg::component_bus_t ref_beat(
        input bf_sample_pkg::sample_bus_t word, input logic imag);
        bf_sample_pkg::component_bus_t r;
        logic [31:0] wt;
        longint a, b, c, d, v;
        for (int bm = 0; bm < `BF_NUM_BEAMS; bm++) begin
            for (int el = 0; el < `BF_NUM_ELEMENTS; el++) begin
                wt = weight_tab[bm * `BF_NUM_ELEMENTS + el];
                a = to_long(word[bm][`BF_SAMPLE_W-1:0]);
                b = to_long(word[bm][2*`BF_SAMPLE_W-1:`BF_SAMPLE_W]);
                c = to_long(wt[15:0]);
                d = to_long(wt[31:16]);
                v = imag ? a * d + b * c : a * c - b * d;
                r[bm][el] = v[`BF_PRODUCT_W-1:0];
            end
        end
        return r;
    endfunction

    // corners show up about one time in four
    function automatic bf_sample_pkg::comp_t random_comp();
        int r;
        r = $urandom_range(7, 0);
        if (r == 0) return 16'h8000;
        if (r == 1) return 16'h7fff;
        return 16'($urandom);
    endfunction

    function automatic bf_sample_pkg::sample_bus_t random_word();
        bf_sample_pkg::sample_bus_t w;
        for (int bm = 0; bm < `BF_NUM_BEAMS; bm++) begin
            w[bm] = {random_comp(), random_comp()};
        end
        return w;
    endfunction

    task automatic compare_bus(input bf_sample_pkg::component_bus_t got,
                               input bf_sample_pkg::component_bus_t exp, input string msg);
        logic shown;
        shown = 1'b0;
        checks++;
        if (got !== exp) begin
            errors++;
            // first differing product only
            for (int bm = 0; bm < `BF_NUM_BEAMS; bm++) begin
                for (int el = 0; el < `BF_NUM_ELEMENTS; el++) begin
                    if (!shown && got[bm][el] !== exp[bm][el]) begin
                        $display("Mismatch at %0t: %s, beam %0d element %0d got %h expected %h",
                                 $time, msg, bm, el, got[bm][el], exp[bm][el]);
                        shown = 1'b1;
                    end
                end
            end
        end
    endtask

    task automatic compare_comp(input bf_sample_pkg::prod_comp_t got,
                                input bf_sample_pkg::prod_comp_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s, got %b expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string msg);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Mismatch at %0t: %s, got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic wait_beats(input int target, input int limit, input string what);
        int n;
        n = 0;
        while (beat_count < target && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (beat_count < target) begin
            errors++;
            $display("timeout waiting for %s, saw %0d of %0d beats", what, beat_count, target);
        end
    endtask

    // returns on the edge that closes the read strobe cycle
    task automatic wait_read(input int limit);
        int n;
        n = 0;
        while (fifo_rd_en !== 1'b1 && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (fifo_rd_en !== 1'b1) begin
            errors++;
            $display("timeout waiting for a fifo read strobe");
        end
    endtask

    // new words join the queue on the falling edge
    task automatic push_word(input bf_sample_pkg::sample_bus_t w);
        @(negedge clk);
        fifo_q.push_back(w);
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    // fifo model with one cycle of read latency
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (fifo_rd_en) begin
            rd_cycles.push_back(cycle);
            rd_count <= rd_count + 1;
            if (fifo_q.size() == 0) begin
                errors++;
                $display("read strobe at %0t while the fifo is empty", $time);
            end else begin
                sample_in <= fifo_q[0];
                exp_q.push_back(fifo_q.pop_front());
            end
        end
        fifo_empty <= (fifo_q.size() == 0);
    end

    // start of each valid burst
    always @(posedge clk) begin
        if (out_valid && !valid_d) begin
            rise_cycles.push_back(cycle);
        end
        valid_d <= out_valid;
    end

    // each valid pair checks the oldest word read with the real beat first
    always @(posedge clk) begin
        if (!reset && out_valid) begin
            compare_flag(out_is_imag, want_imag, "beat order");
            if (!want_imag) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("valid beat at %0t with no word read from the fifo", $time);
                end else begin
                    cur_word = exp_q.pop_front();
                end
            end
            compare_bus(out_data, ref_beat(cur_word, want_imag),
                        want_imag ? "imag beat" : "real beat");
            if (want_imag) begin
                last_im <= out_data;
            end else begin
                last_re <= out_data;
            end
            want_imag = !want_imag;
            beat_count <= beat_count + 1;
        end
    end

    initial begin
        bf_sample_pkg::sample_bus_t w;
        int errs;
        int base;
        int rd_base;
        int rise_base;
        longint p;
        void'($urandom(32'hcf1d));
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // receiver ready with nothing queued
        errs = errors;
        rx_ready <= 1'b1;
        repeat (20) begin
            @(posedge clk);
            compare_flag(fifo_rd_en, 1'b0, "read strobe with empty fifo");
            compare_flag(out_valid, 1'b0, "valid beat with empty fifo");
        end
        report_test("idle_empty", errs);

        // one word
        errs = errors;
        base = beat_count;
        rd_base = rd_count;
        w = {32'h4000_c000, 32'h7fff_8000, 32'h0123_fedc, 32'h8000_7fff};
        push_word(w);
        wait_beats(base + 2, 40, "single word");
        repeat (10) @(posedge clk);
        compare_count(rd_count - rd_base, 1, "read strobes for one word");
        compare_count(beat_count - base, 2, "beats for one word");
        // element 0 is plain scaling by 0x7fff
        for (int bm = 0; bm < `BF_NUM_BEAMS; bm++) begin
            p = to_long(w[bm][`BF_SAMPLE_W-1:0]) * 32767;
            compare_comp(last_re[bm][0], p[31:0], "element 0 real");
            p = to_long(w[bm][2*`BF_SAMPLE_W-1:`BF_SAMPLE_W]) * 32767;
            compare_comp(last_im[bm][0], p[31:0], "element 0 imag");
        end
        report_test("single_word", errs);

        // random words after two all-corner words
        errs = errors;
        base = beat_count;
        push_word({8{16'h8000}});
        push_word({8{16'h7fff}});
        for (int i = 2; i < 60; i++) begin
            push_word(random_word());
        end
        wait_beats(base + 120, 400, "random words");
        report_test("random_words", errs);

        // receiver held off and then dropped during the load cycle
        errs = errors;
        @(posedge clk);
        rx_ready <= 1'b0;
        push_word(random_word());
        push_word(random_word());
        rd_base = rd_count;
        base = beat_count;
        repeat (20) @(posedge clk);
        compare_count(rd_count - rd_base, 0, "read strobes with receiver not ready");
        rx_ready <= 1'b1;
        wait_read(20);
        rx_ready <= 1'b0;
        wait_beats(base + 2, 20, "beats after ready dropped");
        repeat (10) @(posedge clk);
        compare_count(rd_count - rd_base, 1, "read strobes after ready dropped");
        rx_ready <= 1'b1;
        wait_beats(base + 4, 40, "second queued word");
        report_test("back_pressure", errs);

        // back to back transfers from a full queue
        errs = errors;
        @(posedge clk);
        rx_ready <= 1'b0;
        for (int i = 0; i < 6; i++) begin
            push_word(random_word());
        end
        repeat (3) @(posedge clk);
        rd_base = rd_cycles.size();
        rise_base = rise_cycles.size();
        base = beat_count;
        rx_ready <= 1'b1;
        wait_beats(base + 12, 80, "back to back words");
        compare_count(rd_cycles.size() - rd_base, 6, "read strobes in burst");
        compare_count(rise_cycles.size() - rise_base, 6, "valid bursts");
        if (rd_cycles.size() - rd_base == 6 && rise_cycles.size() - rise_base == 6) begin
            for (int i = 0; i < 6; i++) begin
                if (i > 0) begin
                    compare_count(rd_cycles[rd_base + i] - rd_cycles[rd_base + i - 1], 5,
                                  "read strobe spacing");
                end
                compare_count(rise_cycles[rise_base + i] - rd_cycles[rd_base + i], 2,
                              "read strobe to valid delay");
            end
        end
        report_test("back_to_back", errs);

        repeat (5) @(posedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+include
hdl/bf_sample_pkg.sv
hdl/tx_ctrl_pkg.sv
hdl/weight_rom.sv
hdl/cplx_mult.sv
hdl/beam_product_array.sv
hdl/tx_sequencer.sv
hdl/beam_weight_tx.sv
tests/tb_beam_weight_tx.sv

// File: Makefile
# Verilator build and run for the beamforming weight stage

VERILATOR ?= verilator
TOP       ?= tb_beam_weight_tx
DUT_TOP   ?= beam_weight_tx
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then \
		echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
